//--- sources.f
hdl/file_link_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/send_file.sv
hdl/file_link_top.sv
dv/file_link_tb.sv

//--- Bender.yml
package:
  name: file_link

sources:
  - files:
      - hdl/file_link_pkg.sv
      - hdl/byte_fifo.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/send_file.sv
      - hdl/file_link_top.sv
  - target: test
    files:
      - dv/file_link_tb.sv

//--- dv/file_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module file_link_tb;

    localparam int CPB        = file_link_pkg::CLKS_PER_BIT;
    localparam int PRE_LEN    = file_link_pkg::FIFO_DEPTH - 4;  // whole file fits the send fifo
    localparam int PRE_JUNK   = 1;
    localparam int PRE_DELAY  = 8;
    localparam int IDLE_HOLD  = 2 * 10 * CPB;                   // two frame times of silence
    localparam int N_ROWS     = 4;

    // one transfer per row
    typedef struct packed {
        int content_len;
        int junk_cnt;     // non-ack bytes ahead of each ack
        int max_delay;    // cycles before the ack goes out
    } row_t;

    row_t rows [N_ROWS] = '{
        '{0,  0, 0},
        '{3,  1, 12},
        '{20, 2, 40},
        '{40, 1, 6}       // overruns the tx fifo and refills on the fly
    };

    logic                        clk;
    logic                        reset;
    logic                        start_send;
    file_link_pkg::byte_strobe_t send_byte;
    logic                        send_fifo_full;
    logic                        finish_send;
    file_link_pkg::send_state_t  state;
    logic                        txd;
    logic                        rxd;

    logic [31:0] lfsr = 32'ha5e79259;
    logic [7:0]  exp_q [$];      // file as written
    logic [7:0]  cap_q [$];      // bytes seen on txd
    int          start_cnt = 0;  // start bits seen on txd
    int          start_base;
    int          finish_cnt = 0;
    int          fin_base;
    int          cycle_cnt = 0;
    int          cycle_limit;

    file_link_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .start_send     (start_send),
        .send_byte      (send_byte),
        .send_fifo_full (send_fifo_full),
        .finish_send    (finish_send),
        .state          (state),
        .txd            (txd),
        .rxd            (rxd)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input string what);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s, got %h expected %h", $time, what, act, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_state(input file_link_pkg::send_state_t act,
                               input file_link_pkg::send_state_t exp, input string what);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s, got %s expected %s", $time, what,
                     act.name(), exp.name());
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s, got %b expected %b", $time, what, act, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // galois lfsr with taps x^32+x^30+x^26+x^25+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
        return v;
    endfunction

    // framing bytes sit at the three header slots and the last slot
    function automatic bit is_framing(input int idx, input int total);
        return (idx < 3) || (idx == total - 1);
    endfunction

    function automatic file_link_pkg::send_state_t wait_state_for(input int idx);
        case (idx)
            0:       return file_link_pkg::WAIT_ACK_SOH;
            1:       return file_link_pkg::WAIT_ACK_EOT;
            2:       return file_link_pkg::WAIT_ACK_SOT;
            default: return file_link_pkg::WAIT_ACK_EOF;
        endcase
    endfunction

    function automatic logic [7:0] junk_byte(input int j);
        logic [7:0] b;
        b = 8'(rand_bits(8));
        if (b == file_link_pkg::ACK)
            b = ~b;
        return (j == 0) ? 8'h15 : b;     // first junk is always a NAK
    endfunction

    function automatic int transfer_budget(input int len, input int junk, input int delay);
        return (len + 4) * 10 * CPB * 2 + 4 * (delay + (junk + 1) * 10 * CPB);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // serial line model
    ////////////////////////////////////////////////////////////////////////////
    // txd captured on the falling clock edge away from the dut's clock edge
    initial
    begin : line_capture
        logic [7:0] b;
        forever
        begin
            @(negedge clk);
            if (!reset && txd === 1'b0)
            begin
                start_cnt++;
                repeat (CPB / 2) @(negedge clk);   // middle of start bit
                check_flag(txd, 1'b0, "txd start bit");
                for (int i = 0; i < 8; i++)
                begin
                    repeat (CPB) @(negedge clk);
                    b[i] = txd;                    // lsb first
                end
                repeat (CPB) @(negedge clk);
                check_flag(txd, 1'b1, "txd stop bit");
                cap_q.push_back(b);
            end
        end
    end

    always @(negedge clk)
    begin
        if (!reset && finish_send)
            finish_cnt++;
    end

    // drives one 8N1 frame on rxd and returns when the stop bit has ended
    task automatic send_frame(input logic [7:0] b);
        @(posedge clk);
        rxd <= 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            repeat (CPB) @(posedge clk);
            rxd <= b[i];
        end
        repeat (CPB) @(posedge clk);
        rxd <= 1'b1;
        repeat (CPB) @(posedge clk);
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the transfers did not complete", cycle_cnt);
            $display("Test failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // user side and ack responder
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_file(input int len);
        logic [7:0] b;
        exp_q.delete();
        exp_q.push_back(file_link_pkg::SOH);
        exp_q.push_back(file_link_pkg::EOT);
        exp_q.push_back(file_link_pkg::SOT);
        for (int i = 0; i < len; i++)
        begin
            b = 8'(rand_bits(8));
            if (b < 8'h10)
                b = b + 8'h10;                 // keep clear of control codes
            exp_q.push_back(b);
        end
        exp_q.push_back(file_link_pkg::EOF);
    endtask

    // one write every other cycle so the full flag is current
    task automatic write_file();
        foreach (exp_q[i])
        begin
            @(posedge clk);
            while (send_fifo_full)
                @(posedge clk);
            send_byte <= '{data: exp_q[i], valid: 1'b1};
            @(posedge clk);
            send_byte.valid <= 1'b0;
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start_send <= 1'b1;
        @(posedge clk);
        start_send <= 1'b0;
    endtask

    task automatic respond(input int junk, input int max_delay);
        int idx;
        int starts;
        int delay;
        idx = 0;
        while (idx < exp_q.size())
        begin
            @(posedge clk);
            if (cap_q.size() > idx)
            begin
                check_byte(cap_q[idx], exp_q[idx], "byte captured from txd");
                if (is_framing(idx, exp_q.size()))
                begin
                    starts = start_cnt;
                    delay  = int'(rand_bits(8)) % (max_delay + 1);
                    repeat (delay) @(posedge clk);
                    check_state(state, wait_state_for(idx), "state while ack pending");
                    for (int j = 0; j < junk; j++)
                        send_frame(junk_byte(j));
                    check_state(state, wait_state_for(idx), "state after junk bytes");
                    send_frame(file_link_pkg::ACK);
                    check_flag(start_cnt == starts, 1'b1, "txd silent until ack sent");
                    check_flag(finish_cnt == fin_base, 1'b1, "finish_send before last ack");
                end
                idx++;
            end
        end
    endtask

    task automatic wait_finish();
        while (finish_cnt == fin_base)
            @(posedge clk);
        repeat (4) @(posedge clk);
        check_flag(finish_cnt == fin_base + 1, 1'b1, "single finish_send pulse");
        check_state(state, file_link_pkg::IDLE, "state after finish");
        check_flag(start_cnt - start_base == exp_q.size(), 1'b1, "no extra frames on txd");
    endtask

    task automatic run_transfer(input int len, input int junk, input int max_delay,
                                input bit prefill);
        build_file(len);
        cap_q.delete();
        fin_base   = finish_cnt;
        start_base = start_cnt;
        if (prefill)
        begin
            write_file();
            @(posedge clk);
            check_flag(send_fifo_full, 1'b1, "send_fifo_full after a full fill");
            send_byte <= '{data: 8'hee, valid: 1'b1};   // lands on a full fifo and is dropped
            @(posedge clk);
            send_byte.valid <= 1'b0;
            repeat (IDLE_HOLD)
            begin
                @(posedge clk);
                check_flag(txd, 1'b1, "txd idle before start_send");
            end
            check_state(state, file_link_pkg::IDLE, "state before start_send");
            check_flag(cap_q.size() == 0, 1'b1, "nothing sent before start_send");
            pulse_start();
            respond(junk, max_delay);
        end
        else
        begin
            fork
                write_file();
                pulse_start();
                respond(junk, max_delay);
            join
        end
        wait_finish();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        cycle_limit = 200 + IDLE_HOLD + transfer_budget(PRE_LEN, PRE_JUNK, PRE_DELAY);
        for (int r = 0; r < N_ROWS; r++)
            cycle_limit += transfer_budget(rows[r].content_len, rows[r].junk_cnt,
                                           rows[r].max_delay);
        reset      = 1'b1;
        start_send = 1'b0;
        send_byte  = '0;
        rxd        = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_state(state, file_link_pkg::IDLE, "state after reset");
        check_flag(finish_send, 1'b0, "finish_send after reset");
        check_flag(txd, 1'b1, "txd after reset");

        run_transfer(PRE_LEN, PRE_JUNK, PRE_DELAY, 1'b1);   // fill, hold, then go
        for (int r = 0; r < N_ROWS; r++)
            run_transfer(rows[r].content_len, rows[r].junk_cnt, rows[r].max_delay, 1'b0);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/file_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module file_link_top (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        start_send,
    input  wire file_link_pkg::byte_strobe_t send_byte,
    output logic                             send_fifo_full,
    output logic                             finish_send,
    output file_link_pkg::send_state_t       state,
    output logic                             txd,
    input  wire logic                        rxd
);

    file_link_pkg::byte_strobe_t tx_byte;      // sender -> tx fifo
    file_link_pkg::byte_strobe_t rx_byte;      // uart rx -> rx fifo
    logic                        tx_fifo_full;
    logic                        tx_fifo_empty;
    logic                        tx_fifo_rd_en;
    logic [7:0]                  tx_fifo_dout;
    logic                        rx_fifo_empty;
    logic                        rx_read_en;
    logic [7:0]                  rx_data;

    ////////////////////////////////////////////////////////////////////////////
    // transmit path
    ////////////////////////////////////////////////////////////////////////////
    send_file i_send_file (
        .clk            (clk),
        .reset          (reset),
        .start_send     (start_send),
        .send_byte      (send_byte),
        .send_fifo_full (send_fifo_full),
        .finish_send    (finish_send),
        .state          (state),
        .tx_fifo_full   (tx_fifo_full),
        .tx_byte        (tx_byte),
        .rx_data        (rx_data),
        .rx_data_rdy    (~rx_fifo_empty),
        .rx_read_en     (rx_read_en)
    );

    byte_fifo i_tx_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (tx_byte),
        .rd_en (tx_fifo_rd_en),
        .dout  (tx_fifo_dout),
        .empty (tx_fifo_empty),
        .full  (tx_fifo_full)
    );

    uart_tx i_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .fifo_dout  (tx_fifo_dout),
        .fifo_empty (tx_fifo_empty),
        .fifo_rd_en (tx_fifo_rd_en),
        .txd        (txd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // receive path, full flag unused since acks are drained while waiting
    ////////////////////////////////////////////////////////////////////////////
    uart_rx i_uart_rx (
        .clk     (clk),
        .reset   (reset),
        .rxd     (rxd),
        .rx_byte (rx_byte)
    );

    byte_fifo i_rx_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (rx_byte),
        .rd_en (rx_read_en),
        .dout  (rx_data),
        .empty (rx_fifo_empty),
        .full  ()
    );

endmodule

`default_nettype wire

//--- hdl/send_file.sv
`timescale 1ns/1ps
`default_nettype none

module send_file (
    input  wire logic                        clk,
    input  wire logic                        reset,
    // user side
    input  wire logic                        start_send,     // pulse, idle only
    input  wire file_link_pkg::byte_strobe_t send_byte,      // into send fifo
    output logic                             send_fifo_full,
    output logic                             finish_send,    // one cycle in DONE
    output file_link_pkg::send_state_t       state,          // debug
    // tx fifo side
    input  wire logic                        tx_fifo_full,
    output file_link_pkg::byte_strobe_t      tx_byte,
    // rx fifo side
    input  wire logic [7:0]                  rx_data,        // head of rx fifo
    input  wire logic                        rx_data_rdy,    // rx fifo not empty
    output logic                             rx_read_en
);

    logic       send_fifo_empty;
    logic [7:0] send_fifo_dout;
    logic       is_send;          // in one of the SEND states
    logic       is_wait;          // in one of the WAIT states
    logic       move;             // byte goes send fifo -> tx fifo this cycle
    logic [7:0] frame_code;       // code that ends the current SEND state
    logic       code_sent;
    logic       ack_seen;

    ////////////////////////////////////////////////////////////////////////////
    // send fifo, user fills it before start
    ////////////////////////////////////////////////////////////////////////////
    byte_fifo i_send_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (send_byte),
        .rd_en (move),
        .dout  (send_fifo_dout),
        .empty (send_fifo_empty),
        .full  (send_fifo_full)
    );

    // state decode
    always_comb
    begin
        is_send    = 1'b0;
        is_wait    = 1'b0;
        frame_code = file_link_pkg::EOF;   // content runs until EOF
        case (state)
            file_link_pkg::SEND_SOH:
            begin
                is_send    = 1'b1;
                frame_code = file_link_pkg::SOH;
            end
            file_link_pkg::SEND_EOT:
            begin
                is_send    = 1'b1;
                frame_code = file_link_pkg::EOT;
            end
            file_link_pkg::SEND_SOT:
            begin
                is_send    = 1'b1;
                frame_code = file_link_pkg::SOT;
            end
            file_link_pkg::SEND_CONTENT: is_send = 1'b1;
            file_link_pkg::WAIT_ACK_SOH,
            file_link_pkg::WAIT_ACK_EOT,
            file_link_pkg::WAIT_ACK_SOT,
            file_link_pkg::WAIT_ACK_EOF: is_wait = 1'b1;
            default: ;
        endcase
    end

    assign move          = is_send & ~send_fifo_empty & ~tx_fifo_full;
    assign tx_byte.data  = send_fifo_dout;
    assign tx_byte.valid = move;
    assign code_sent     = move & (send_fifo_dout == frame_code);
    assign rx_read_en    = is_wait & rx_data_rdy;   // drain anything waiting
    assign ack_seen      = rx_read_en & (rx_data == file_link_pkg::ACK);
    assign finish_send   = (state == file_link_pkg::DONE);

    ////////////////////////////////////////////////////////////////////////////
    // stop-and-wait fsm
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
            state <= file_link_pkg::IDLE;
        else
        begin
            case (state)
                file_link_pkg::IDLE:
                    if (start_send)
                        state <= file_link_pkg::SEND_SOH;
                file_link_pkg::SEND_SOH:
                    if (code_sent)
                        state <= file_link_pkg::WAIT_ACK_SOH;
                file_link_pkg::WAIT_ACK_SOH:
                    if (ack_seen)
                        state <= file_link_pkg::SEND_EOT;
                file_link_pkg::SEND_EOT:
                    if (code_sent)
                        state <= file_link_pkg::WAIT_ACK_EOT;
                file_link_pkg::WAIT_ACK_EOT:
                    if (ack_seen)
                        state <= file_link_pkg::SEND_SOT;
                file_link_pkg::SEND_SOT:
                    if (code_sent)
                        state <= file_link_pkg::WAIT_ACK_SOT;
                file_link_pkg::WAIT_ACK_SOT:
                    if (ack_seen)
                        state <= file_link_pkg::SEND_CONTENT;
                file_link_pkg::SEND_CONTENT:
                    if (code_sent)               // EOF just went out
                        state <= file_link_pkg::WAIT_ACK_EOF;
                file_link_pkg::WAIT_ACK_EOF:
                    if (ack_seen)
                        state <= file_link_pkg::DONE;
                default:
                    state <= file_link_pkg::IDLE;  // DONE and stray codes
            endcase
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        tx_byte.valid |-> !tx_fifo_full);

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   rxd,      // async serial in
    output file_link_pkg::byte_strobe_t rx_byte   // valid for one cycle per frame
);

    logic                                rxd_meta;
    logic                                rxd_sync;
    logic                                rxd_last;  // for edge detect
    logic                                fall;
    logic                                busy;
    logic [file_link_pkg::BIT_CNT_W-1:0] bit_cnt;
    logic [3:0]                          bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [7:0]                          shreg;

    ////////////////////////////////////////////////////////////////////////////
    // two-flop synchronizer plus edge detect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    assign fall = rxd_last & ~rxd_sync;   // high to low, start of frame

    ////////////////////////////////////////////////////////////////////////////
    // frame sampler
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy          <= 1'b0;
            bit_cnt       <= '0;
            bit_idx       <= '0;
            rx_byte.valid <= 1'b0;
        end
        else
        begin
            rx_byte.valid <= 1'b0;          // strobe by default
            if (!busy)
            begin
                if (fall)
                begin
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                    bit_idx <= '0;
                end
            end
            else if (bit_idx == 4'd0)
            begin
                // half a bit in, start must still be low
                if (bit_cnt == file_link_pkg::BIT_HALF)
                begin
                    bit_cnt <= '0;
                    if (rxd_sync)
                        busy <= 1'b0;       // glitch, back to hunting
                    else
                        bit_idx <= 4'd1;
                end
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
            else if (bit_cnt == file_link_pkg::BIT_LAST)
            begin
                bit_cnt <= '0;              // now at mid-bit
                if (bit_idx == 4'd9)
                begin
                    busy <= 1'b0;
                    if (rxd_sync)
                    begin
                        rx_byte.data  <= shreg;
                        rx_byte.valid <= 1'b1;
                    end                     // low stop bit, frame dropped
                end
                else
                begin
                    shreg   <= {rxd_sync, shreg[7:1]};  // lsb arrives first
                    bit_idx <= bit_idx + 1'b1;
                end
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    a_single_strobe: assert property (@(posedge clk) disable iff (reset)
        rx_byte.valid |=> !rx_byte.valid);

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] fifo_dout,   // head of tx fifo
    input  wire logic       fifo_empty,
    output logic            fifo_rd_en,  // one-cycle pop on load
    output logic            txd          // serial out, idles high
);

    logic                                busy;
    logic [file_link_pkg::BIT_CNT_W-1:0] bit_cnt;  // clocks within a bit
    logic [3:0]                          bit_idx;  // 0 start, 1..8 data, 9 stop
    logic [8:0]                          shreg;    // {stop, data}

    // pull a byte as soon as the line is free
    assign fifo_rd_en = ~busy & ~fifo_empty;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end
        else if (!busy)
        begin
            if (fifo_rd_en)
            begin
                shreg   <= {1'b1, fifo_dout};
                txd     <= 1'b0;            // start bit begins next cycle
                busy    <= 1'b1;
                bit_cnt <= '0;
                bit_idx <= '0;
            end
        end
        else if (bit_cnt == file_link_pkg::BIT_LAST)
        begin
            bit_cnt <= '0;
            if (bit_idx == 4'd9)
                busy <= 1'b0;               // stop bit done, txd already high
            else
            begin
                bit_idx <= bit_idx + 1'b1;
                txd     <= shreg[0];        // lsb first, stop bit falls out last
                shreg   <= {1'b1, shreg[8:1]};
            end
        end
        else
            bit_cnt <= bit_cnt + 1'b1;
    end

    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        !busy |-> txd);

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire file_link_pkg::byte_strobe_t wr,     // byte plus write strobe
    input  wire logic                       rd_en,  // pop head
    output logic [7:0]                      dout,   // fall-through head
    output logic                            empty,
    output logic                            full
);

    logic [7:0]                           mem [file_link_pkg::FIFO_DEPTH];
    logic [file_link_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [file_link_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [file_link_pkg::FIFO_PTR_W:0]   count;    // one bit wider than ptrs
    logic                                 push;
    logic                                 pop;

    assign push  = wr.valid & ~full;   // writes into a full fifo are lost
    assign pop   = rd_en & ~empty;
    assign empty = (count == '0);
    assign full  = (count == (file_link_pkg::FIFO_PTR_W + 1)'(file_link_pkg::FIFO_DEPTH));
    assign dout  = mem[rd_ptr];         // head always visible

    // storage array
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr.data;
    end

    // pointers wrap on their own as depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push & ~pop)
                count <= count + 1'b1;
            else if (pop & ~push)
                count <= count - 1'b1;  // count holds on push plus pop
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= (file_link_pkg::FIFO_PTR_W + 1)'(file_link_pkg::FIFO_DEPTH));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> !empty);

endmodule

`default_nettype wire

//--- hdl/file_link_pkg.sv
`default_nettype none

package file_link_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // link control codes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [7:0] SOH = 8'h01;   // start of header
    localparam logic [7:0] SOT = 8'h02;   // start of text
    localparam logic [7:0] EOT = 8'h03;   // end of header block
    localparam logic [7:0] EOF = 8'h04;   // end of file
    localparam logic [7:0] ACK = 8'h06;

    // fifo sizing
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = 4;        // log2 of depth

    // serial bit timing and the counters that walk each bit
    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CNT_W = 3;
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_W-1:0] BIT_HALF = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // a byte with its write or arrival strobe
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } byte_strobe_t;

    // sender fsm states
    typedef enum logic [3:0] {
        IDLE         = 4'd0,
        SEND_SOH     = 4'd1,
        WAIT_ACK_SOH = 4'd2,
        SEND_EOT     = 4'd3,
        WAIT_ACK_EOT = 4'd4,
        SEND_SOT     = 4'd5,
        WAIT_ACK_SOT = 4'd6,
        SEND_CONTENT = 4'd7,
        WAIT_ACK_EOF = 4'd8,
        DONE         = 4'd9
    } send_state_t;

endpackage

`default_nettype wire
